// File: build.f
+incdir+logic
+incdir+test
logic/softmax_pkg.sv
logic/exp_step_lanes.sv
logic/row_sum_accumulator.sv
logic/sum_fifo.sv
logic/reciprocal_divider.sv
logic/softmax_norm_top.sv
test/tb_softmax_norm.sv

// File: logic/exp_step_lanes.sv
/*
  Combinational exponent approximation for one beat.
  Each lane adds 256 >> step, where the step comes from the distance to the row maximum.
*/
`timescale 1ns/1ps
`default_nettype none

`include "softmax_settings.svh"

module exp_step_lanes
  import softmax_pkg::*;
(
  input  logic signed [`SM_SCORE_W-1:0] max_i,
  input  score_vec_t                    scores_i,
  output logic [`SM_ACC_W-1:0]          contrib_o
);

  localparam logic [`SM_ACC_W-1:0] UNIT = 256;

  logic [`SM_LANES-1:0][`SM_SCORE_W-1:0] diff;
  logic [`SM_LANES-1:0][`SM_STEP_W-1:0]  step;

  always_comb begin
    contrib_o = '0;
    for (int l = 0; l < `SM_LANES; l++) begin
      // max_i is never below a lane, so the difference fits unsigned
      diff[l]   = max_i - scores_i[l];
      step[l]   = exp_step(diff[l]);
      contrib_o = contrib_o + (UNIT >> step[l]);
    end
  end

endmodule

`default_nettype wire

// File: logic/reciprocal_divider.sv
/*
  Serial restoring divider that turns a row sum into its reciprocal.
  One quotient bit per cycle; the result is held until the sink accepts it.
*/
`timescale 1ns/1ps
`default_nettype none

`include "softmax_settings.svh"

module reciprocal_divider
  import softmax_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         entry_valid_i,
  input  row_sum_t     entry_i,
  input  logic         result_ready_i,
  output logic         take_o,
  output norm_result_t result_o,
  output logic         result_valid_o
);

  localparam int ITER_W = $clog2(`SM_DIV_CYCLES);

  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    HOLD
  } div_state_e;

  div_state_e              state_q;
  logic [ITER_W-1:0]       iter_q;
  row_sum_t                entry_q;
  logic [`SM_ACC_W-1:0]    rem_q;
  logic [`SM_ACC_W:0]      rem_shift;
  logic [`SM_ACC_W:0]      divisor;
  logic [`SM_RECIP_W-1:0]  quo_q;
  logic                    num_bit;
  logic                    rem_ge;

  assign take_o = (state_q == IDLE) && entry_valid_i;

  // The numerator is a single set bit, fed in on its own iteration
  assign num_bit   = iter_q == ITER_W'(`SM_DIV_CYCLES - 1 - `SM_RECIP_NUM_LOG2);
  assign rem_shift = {rem_q, num_bit};
  assign divisor   = {1'b0, entry_q.exp_sum};
  assign rem_ge    = rem_shift >= divisor;

  assign result_o.sum   = entry_q;
  assign result_o.recip = quo_q;
  assign result_valid_o = state_q == HOLD;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      iter_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (take_o) begin
            state_q <= DIVIDE;
            iter_q  <= '0;
          end
        end
        DIVIDE: begin
          iter_q <= iter_q + 1'b1;
          if (iter_q == ITER_W'(`SM_DIV_CYCLES - 1)) begin
            state_q <= HOLD;
          end
        end
        HOLD: begin
          if (result_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // The remainder stays below the divisor, so it always fits SM_ACC_W bits
  always_ff @(posedge clk_i) begin
    if (take_o) begin
      entry_q <= entry_i;
      rem_q   <= '0;
      quo_q   <= '0;
    end else if (state_q == DIVIDE) begin
      rem_q <= rem_ge ? `SM_ACC_W'(rem_shift - divisor) : rem_shift[`SM_ACC_W-1:0];
      quo_q <= {quo_q[`SM_RECIP_W-2:0], rem_ge};
    end
  end

  // The accumulator always adds at least 256 for the lane at the maximum
  nonzero_divisor_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    take_o |-> entry_i.exp_sum != '0
  );

endmodule

`default_nettype wire

// File: logic/row_sum_accumulator.sv
/*
  Producer of row sums. Tracks the running maximum, rescales the partial sum when it grows
  and pushes {max, sum} to the FIFO three cycles after a row's last beat.
*/
`timescale 1ns/1ps
`default_nettype none

`include "softmax_settings.svh"

module row_sum_accumulator
  import softmax_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  row_beat_t beat_i,
  input  logic      beat_valid_i,
  input  logic      credit_return_i,
  output logic      beat_ready_o,
  output logic      push_o,
  output row_sum_t  push_data_o
);

  localparam int CREDIT_W = $clog2(`SM_FIFO_DEPTH + 1);

  logic [CREDIT_W-1:0] credit_q;
  logic                beat_fire;
  logic                credit_spend;

  score_t beat_max;
  score_t new_max;
  score_t run_max_q;
  logic   row_open_q;

  logic       s1_valid_q;
  logic       s1_last_q;
  logic       s1_first_q;
  score_t     s1_max_q;
  score_t     s1_prev_max_q;
  score_vec_t s1_scores_q;

  logic [`SM_ACC_W-1:0]   contrib;
  logic [`SM_SCORE_W-1:0] rescale_diff;

  logic                  s2_valid_q;
  logic                  s2_last_q;
  logic                  s2_first_q;
  score_t                s2_max_q;
  logic [`SM_ACC_W-1:0]  s2_contrib_q;
  logic [`SM_STEP_W-1:0] s2_shift_q;

  logic [`SM_ACC_W-1:0] acc_q;
  logic [`SM_ACC_W-1:0] acc_next;

  assign beat_ready_o = credit_q != '0;
  assign beat_fire    = beat_valid_i && beat_ready_o;

  // A credit is reserved as the last beat enters, so its later push always finds room
  assign credit_spend = beat_fire && beat_i.last;

  // Stage 0
  always_comb begin
    beat_max = beat_i.scores[0];
    for (int l = 1; l < `SM_LANES; l++) begin
      if (beat_i.scores[l] > beat_max) begin
        beat_max = beat_i.scores[l];
      end
    end
    new_max = (row_open_q && (run_max_q > beat_max)) ? run_max_q : beat_max;
  end

  // Stage 1
  exp_step_lanes u_lanes (
    .max_i    (s1_max_q),
    .scores_i (s1_scores_q),
    .contrib_o(contrib)
  );

  assign rescale_diff = s1_max_q - s1_prev_max_q;

  // Stage 2 scales the old sum down by the growth of the maximum
  assign acc_next = s2_contrib_q + (s2_first_q ? '0 : (acc_q >> s2_shift_q));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_open_q <= 1'b0;
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
      push_o     <= 1'b0;
      credit_q   <= CREDIT_W'(`SM_FIFO_DEPTH);
    end else begin
      if (beat_fire) begin
        row_open_q <= !beat_i.last;
      end
      s1_valid_q <= beat_fire;
      s2_valid_q <= s1_valid_q;
      push_o     <= s2_valid_q && s2_last_q;
      credit_q   <= credit_q - CREDIT_W'(credit_spend) + CREDIT_W'(credit_return_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      run_max_q     <= new_max;
      s1_last_q     <= beat_i.last;
      s1_first_q    <= !row_open_q;
      s1_max_q      <= new_max;
      s1_prev_max_q <= run_max_q;
      s1_scores_q   <= beat_i.scores;
    end
    if (s1_valid_q) begin
      s2_last_q    <= s1_last_q;
      s2_first_q   <= s1_first_q;
      s2_max_q     <= s1_max_q;
      s2_contrib_q <= contrib;
      s2_shift_q   <= exp_step(rescale_diff);
    end
    if (s2_valid_q) begin
      acc_q               <= acc_next;
      push_data_o.row_max <= s2_max_q;
      push_data_o.exp_sum <= acc_next;
    end
  end

  // Returns from the FIFO must never outnumber the credits handed out
  credit_bound_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CREDIT_W'(`SM_FIFO_DEPTH)
  );

endmodule

`default_nettype wire

// File: logic/softmax_norm_top.sv
/*
  Softmax row normalizer: row sum accumulator, credit-controlled sum FIFO
  and reciprocal divider. Feed score beats in, collect {max, sum, reciprocal} per row.
*/
`timescale 1ns/1ps
`default_nettype none

module softmax_norm_top
  import softmax_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  row_beat_t    beat_i,
  input  logic         beat_valid_i,
  input  logic         result_ready_i,
  output logic         beat_ready_o,
  output norm_result_t result_o,
  output logic         result_valid_o
);

  logic     push;
  row_sum_t push_data;
  logic     credit_return;
  logic     entry_valid;
  row_sum_t entry;
  logic     take;

  row_sum_accumulator u_accumulator (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .beat_i         (beat_i),
    .beat_valid_i   (beat_valid_i),
    .credit_return_i(credit_return),
    .beat_ready_o   (beat_ready_o),
    .push_o         (push),
    .push_data_o    (push_data)
  );

  sum_fifo u_fifo (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .push_data_i    (push_data),
    .take_i         (take),
    .entry_valid_o  (entry_valid),
    .entry_o        (entry),
    .credit_return_o(credit_return)
  );

  reciprocal_divider u_divider (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .entry_valid_i (entry_valid),
    .entry_i       (entry),
    .result_ready_i(result_ready_i),
    .take_o        (take),
    .result_o      (result_o),
    .result_valid_o(result_valid_o)
  );

endmodule

`default_nettype wire

// File: logic/softmax_pkg.sv
/*
  Types shared by the softmax row normalizer and its testbench,
  plus the rounded exponent step used by every shift in the datapath.
*/
`default_nettype none

`include "softmax_settings.svh"

package softmax_pkg;

  typedef logic signed [`SM_SCORE_W-1:0] score_t;

  // Elements keep their sign because score_t is a signed named type
  typedef score_t [`SM_LANES-1:0] score_vec_t;

  typedef struct packed {
    logic       last;
    score_vec_t scores;
  } row_beat_t;

  typedef struct packed {
    score_t                row_max;
    logic [`SM_ACC_W-1:0] exp_sum;
  } row_sum_t;

  typedef struct packed {
    row_sum_t                sum;
    logic [`SM_RECIP_W-1:0] recip;
  } norm_result_t;

  // Difference over 32, rounded up when bit 4 is set
  function automatic logic [`SM_STEP_W-1:0] exp_step(input logic [`SM_SCORE_W-1:0] diff);
    return diff[`SM_SCORE_W-1:5] + diff[4];
  endfunction

endpackage

`default_nettype wire

// File: logic/softmax_settings.svh
/*
  Build-time sizes of the softmax row normalizer.
  Include wherever lane count, widths or divider constants are needed.
*/
`ifndef SOFTMAX_SETTINGS_SVH
`define SOFTMAX_SETTINGS_SVH

// Scores per input beat
`define SM_LANES 4
`define SM_SCORE_W 8

// A step of 8 still fits and 256 >> 8 leaves a contribution of 1
`define SM_STEP_W 4

// Holds rows of up to 255 beats at 1024 per beat
`define SM_ACC_W 20

`define SM_FIFO_DEPTH 4

// Divider computes 2**SM_RECIP_NUM_LOG2 / sum
`define SM_RECIP_NUM_LOG2 23
`define SM_RECIP_W 16
`define SM_DIV_CYCLES 24

`endif

// File: logic/sum_fifo.sv
/*
  Small FIFO of finished row sums between the accumulator and the divider.
  Every pop sends one credit back to the producer on the following cycle.
*/
`timescale 1ns/1ps
`default_nettype none

`include "softmax_settings.svh"

module sum_fifo
  import softmax_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  row_sum_t push_data_i,
  input  logic     take_i,
  output logic     entry_valid_o,
  output row_sum_t entry_o,
  output logic     credit_return_o
);

  localparam int PTR_W = $clog2(`SM_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`SM_FIFO_DEPTH + 1);

  row_sum_t         mem_q [`SM_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`SM_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign entry_valid_o = count_q != '0;
  assign entry_o       = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q        <= '0;
      rd_ptr_q        <= '0;
      count_q         <= '0;
      credit_return_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (take_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q         <= count_q + CNT_W'(push_i) - CNT_W'(take_i);
      credit_return_o <= take_i;
    end
  end

  no_overflow_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (count_q < CNT_W'(`SM_FIFO_DEPTH)) || take_i
  );

  no_underflow_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    take_i |-> count_q != '0
  );

endmodule

`default_nettype wire

// File: test/softmax_norm_ref.svh
/*
  Reference model of the row normalizer and the table of directed rows.
  Included inside the testbench module, after the package import.
*/
`ifndef SOFTMAX_NORM_REF_SVH
`define SOFTMAX_NORM_REF_SVH

`include "softmax_settings.svh"

localparam int MAX_BEATS  = 8;
localparam int CASE_COUNT = 6;

// Distance to the maximum over 32, rounded to nearest
function automatic int rounded_step(input int diff);
  return (diff + 16) / 32;
endfunction

function automatic int lane_contrib(input score_vec_t scores, input int row_max);
  int total;
  total = 0;
  for (int l = 0; l < `SM_LANES; l++) begin
    total += 256 >> rounded_step(row_max - scores[l]);
  end
  return total;
endfunction

// Running maximum and rescaled exponent sum over the beats of one row
function automatic void model_row(input score_vec_t beats [MAX_BEATS], input int count,
                                  output int row_max, output int sum);
  int beat_max;
  int new_max;
  row_max = 0;
  sum     = 0;
  for (int b = 0; b < count; b++) begin
    beat_max = -128;
    for (int l = 0; l < `SM_LANES; l++) begin
      if (beats[b][l] > beat_max) begin
        beat_max = beats[b][l];
      end
    end
    new_max = (b == 0 || beat_max > row_max) ? beat_max : row_max;
    sum     = lane_contrib(beats[b], new_max) +
              ((b == 0) ? 0 : (sum >> rounded_step(new_max - row_max)));
    row_max = new_max;
  end
endfunction

function automatic int expected_recip(input int sum);
  return (1 << `SM_RECIP_NUM_LOG2) / sum;
endfunction

// Words in issue order, lane 3 in the top byte
typedef struct packed {
  logic [3:0]             beats;
  score_vec_t [0:3]       words;
  logic [7:0]             ready_pat;
  logic [`SM_SCORE_W-1:0] exp_max;
  logic [`SM_ACC_W-1:0]   exp_sum;
} row_case_t;

localparam row_case_t CASES [CASE_COUNT] = '{
  // Equal scores, every lane at the maximum
  '{4'd1, {32'h14141414, 32'h0, 32'h0, 32'h0}, 8'hFF, 8'h14, 20'd1024},
  // Maximum rises 0, 32, 64 and halves the sum twice
  '{4'd3, {32'h00000000, 32'h00002020, 32'h00283040, 32'h0}, 8'hA5, 8'h40, 20'd1216},
  // Jump from -100 to 100 shifts the old sum by 6
  '{4'd2, {32'h80889C9C, 32'h9CCE3264, 32'h0, 32'h0}, 8'h0F, 8'h64, 20'd344},
  '{4'd1, {32'h7F00807F, 32'h0, 32'h0, 32'h0}, 8'hFF, 8'h7F, 20'd529},
  // Maximum set by the first beat and never raised
  '{4'd3, {32'h50505050, 32'hB0503010, 32'h00000000, 32'h0}, 8'h33, 8'h50, 20'd1608},
  '{4'd1, {32'hFBFBFBFB, 32'h0, 32'h0, 32'h0}, 8'hFF, 8'hFB, 20'd1024}
};

`endif

// File: test/tb_softmax_norm.sv
/*
  Testbench for the softmax row normalizer. Runs the directed table, a back-pressure
  phase and random rows, and scores every result in row order.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_softmax_norm
  import softmax_pkg::*;
();

  `include "softmax_norm_ref.svh"

  localparam int RAND_ROWS = 20;

  logic         clk_i;
  logic         rst_ni;
  row_beat_t    beat_i;
  logic         beat_valid_i;
  logic         result_ready_i;
  logic         beat_ready_o;
  norm_result_t result_o;
  logic         result_valid_o;

  norm_result_t exp_q [$];
  logic [7:0]   pat_q [$];
  integer       seed       = 19550;
  int           errors     = 0;
  int           checks     = 0;
  int           results    = 0;
  bit           stall_sink = 1'b0;

  softmax_norm_top u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .beat_i        (beat_i),
    .beat_valid_i  (beat_valid_i),
    .result_ready_i(result_ready_i),
    .beat_ready_o  (beat_ready_o),
    .result_o      (result_o),
    .result_valid_o(result_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic compare(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  function automatic int table_beats();
    int total;
    total = 0;
    for (int i = 0; i < CASE_COUNT; i++) begin
      total += CASES[i].beats;
    end
    return total;
  endfunction

  task automatic queue_expected(input int row_max, input int sum, input logic [7:0] pat);
    norm_result_t r;
    int           recip;
    recip         = expected_recip(sum);
    r.sum.row_max = row_max[`SM_SCORE_W-1:0];
    r.sum.exp_sum = sum[`SM_ACC_W-1:0];
    r.recip       = recip[`SM_RECIP_W-1:0];
    exp_q.push_back(r);
    pat_q.push_back(pat);
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_beat(input row_beat_t beat);
    beat_i       = beat;
    beat_valid_i = 1'b1;
    while (!beat_ready_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
  endtask

  task automatic drive_row(input score_vec_t beats [MAX_BEATS], input int count);
    row_beat_t beat;
    for (int b = 0; b < count; b++) begin
      beat.scores = beats[b];
      beat.last   = (b == count - 1);
      send_beat(beat);
    end
  endtask

  task automatic run_case(input int idx);
    score_vec_t beats [MAX_BEATS];
    for (int b = 0; b < MAX_BEATS; b++) begin
      beats[b] = (b < 4) ? CASES[idx].words[b] : '0;
    end
    queue_expected(CASES[idx].exp_max, CASES[idx].exp_sum, CASES[idx].ready_pat);
    drive_row(beats, CASES[idx].beats);
  endtask

  task automatic random_row();
    score_vec_t beats [MAX_BEATS];
    int         count;
    int         row_max;
    int         sum;
    logic [7:0] pat;
    count = 1 + ($unsigned($random(seed)) % MAX_BEATS);
    for (int b = 0; b < MAX_BEATS; b++) begin
      beats[b] = $random(seed);
    end
    // Bits 0 and 4 keep every gap in result_ready_i short
    pat = $random(seed) | 8'h11;
    model_row(beats, count, row_max, sum);
    queue_expected(row_max, sum, pat);
    drive_row(beats, count);
  endtask

  task automatic drain_results();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  // The output side drives result_ready_i from the pattern of the oldest open row
  initial begin : sink
    norm_result_t want;
    norm_result_t held_val;
    logic [7:0]   pat;
    logic         ready;
    logic         held;
    int           cycle;
    cycle = 0;
    held  = 1'b0;
    forever begin
      @(negedge clk_i);
      cycle++;
      if (held) begin
        compare("result_valid_o", result_valid_o, 1);
        compare("result_o", result_o, held_val);
      end
      pat            = (pat_q.size() != 0) ? pat_q[0] : 8'hFF;
      ready          = rst_ni && !stall_sink && pat[cycle % 8];
      result_ready_i = ready;
      held           = result_valid_o && !ready;
      held_val       = result_o;
      if (ready && result_valid_o) begin
        results++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Result %0d arrived with no row outstanding", results);
        end else begin
          want = exp_q.pop_front();
          pat_q.delete(0);
          compare("result_o.sum.row_max", $unsigned(result_o.sum.row_max),
                  $unsigned(want.sum.row_max));
          compare("result_o.sum.exp_sum", result_o.sum.exp_sum, want.sum.exp_sum);
          compare("result_o.recip", result_o.recip, want.recip);
        end
      end
    end
  end

  initial begin : watchdog
    int limit;
    limit = 2 * table_beats() + RAND_ROWS * MAX_BEATS +
            (2 * CASE_COUNT + RAND_ROWS) * (`SM_DIV_CYCLES + 8) + 100;
    repeat (limit) @(posedge clk_i);
    $display("Timeout after %0d cycles with %0d rows still waiting", limit, exp_q.size());
    $display("Checks failed");
    $finish;
  end

  initial begin : main
    rst_ni         = 1'b0;
    beat_i         = '0;
    beat_valid_i   = 1'b0;
    result_ready_i = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    compare("beat_ready_o", beat_ready_o, 1);
    compare("result_valid_o", result_valid_o, 0);

    // Directed rows back to back
    for (int i = 0; i < CASE_COUNT; i++) begin
      run_case(i);
    end
    beat_valid_i = 1'b0;
    drain_results();

    // One row in the divider and four in the FIFO use up every credit
    stall_sink = 1'b1;
    for (int i = 0; i < CASE_COUNT - 1; i++) begin
      run_case(i);
    end
    beat_valid_i = 1'b0;
    for (int n = 0; n < 20 && beat_ready_o; n++) begin
      @(negedge clk_i);
    end
    compare("beat_ready_o", beat_ready_o, 0);
    stall_sink = 1'b0;
    run_case(CASE_COUNT - 1);
    beat_valid_i = 1'b0;
    drain_results();

    for (int i = 0; i < RAND_ROWS; i++) begin
      random_row();
    end
    beat_valid_i = 1'b0;
    drain_results();

    // A stray result after the last row would still show up in this window
    repeat (`SM_DIV_CYCLES + 8) @(negedge clk_i);
    compare("result count", results, 2 * CASE_COUNT + RAND_ROWS);

    $display("Summary: %0d results, %0d checks, %0d errors", results, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
